// File: common/drac_pkg.sv
// shared definitions for the branch resolution pipeline
// word widths, opcode and funct3 encodings, instruction type enum
// instruction word union with its b, j and i format views
// stage structs for decode and execute, register write request
package drac_pkg;

    localparam int XLEN      = 64;          // data and pc width
    localparam int INST_SIZE = 32;
    localparam int REG_ADDR  = 5;
    localparam int NUM_REGS  = 32;

    typedef logic [XLEN-1:0]     bus64_t;
    typedef logic [XLEN-1:0]     addrPC_t;
    typedef logic [REG_ADDR-1:0] reg_addr_t;

    // major opcodes handled here, everything else decodes as nop
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    // funct3 of the conditional branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef enum logic [3:0] {
        NOP,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU
    } instr_type_t;

    typedef struct packed {
        logic        imm12;     // sign bit
        logic [5:0]  imm10_5;
        reg_addr_t   rs2;
        reg_addr_t   rs1;
        logic [2:0]  func3;
        logic [3:0]  imm4_1;
        logic        imm11;
        logic [6:0]  opcode;
    } b_type_t;

    typedef struct packed {
        logic        imm20;     // sign bit
        logic [9:0]  imm10_1;
        logic        imm11;
        logic [7:0]  imm19_12;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } j_type_t;

    typedef struct packed {
        logic [11:0] imm11_0;
        reg_addr_t   rs1;
        logic [2:0]  func3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_type_t;

    // one 32-bit word, read through the view the opcode picks
    typedef union packed {
        logic [INST_SIZE-1:0] raw;
        b_type_t              b_type;
        j_type_t              j_type;
        i_type_t              i_type;
    } instr_u;

    typedef struct packed {
        logic        valid;
        instr_type_t instr_type;
        addrPC_t     pc;
        bus64_t      imm;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        reg_addr_t   rd;
    } decode_out_t;

    typedef struct packed {
        logic        valid;
        instr_type_t instr_type;
        addrPC_t     pc;
        logic        taken;
        addrPC_t     target;
        addrPC_t     result;    // next pc
        bus64_t      reg_data;  // link value pc+4
        reg_addr_t   rd;
    } exec_out_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        bus64_t    data;
    } reg_wr_t;

endpackage

// File: source/branch_decode_stage.sv
// decode stage of the branch pipeline
// classifies jal, jalr and conditional branches, builds immediates
// early jal redirect, decode pipeline register
`timescale 1ns/1ns

module branch_decode_stage (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  instr_valid_i,
    input  drac_pkg::instr_u      instr_i,
    input  drac_pkg::addrPC_t     pc_i,
    output logic                  redirect_o,
    output drac_pkg::addrPC_t     redirect_target_o,
    output drac_pkg::decode_out_t decode_o
);
    import drac_pkg::*;

    instr_type_t instr_type;
    bus64_t      imm;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    decode_out_t decode_q;

    // opcode sits at the same bits in every view
    always_comb begin
        instr_type = NOP;
        imm        = '0;
        rs1        = '0;
        rs2        = '0;
        rd         = '0;
        case (instr_i.b_type.opcode)
            OP_BRANCH: begin
                rs1 = instr_i.b_type.rs1;
                rs2 = instr_i.b_type.rs2;
                imm = {{51{instr_i.b_type.imm12}}, instr_i.b_type.imm12,
                       instr_i.b_type.imm11, instr_i.b_type.imm10_5,
                       instr_i.b_type.imm4_1, 1'b0};   // b-imm, bit 0 always zero
                case (instr_i.b_type.func3)
                    F3_BEQ:  instr_type = BEQ;
                    F3_BNE:  instr_type = BNE;
                    F3_BLT:  instr_type = BLT;
                    F3_BGE:  instr_type = BGE;
                    F3_BLTU: instr_type = BLTU;
                    F3_BGEU: instr_type = BGEU;
                    default: instr_type = NOP;  // 010, 011 are not branches
                endcase
            end
            OP_JAL: begin
                instr_type = JAL;
                rd         = instr_i.j_type.rd;
                imm        = {{43{instr_i.j_type.imm20}}, instr_i.j_type.imm20,
                              instr_i.j_type.imm19_12, instr_i.j_type.imm11,
                              instr_i.j_type.imm10_1, 1'b0};
            end
            OP_JALR: begin
                instr_type = JALR;
                rs1        = instr_i.i_type.rs1;
                rd         = instr_i.i_type.rd;
                imm        = {{52{instr_i.i_type.imm11_0[11]}}, instr_i.i_type.imm11_0};
            end
            default: begin
                instr_type = NOP;   // anything else passes through as a nop
            end
        endcase
    end

    // jal target known here, no operand needed
    assign redirect_o        = instr_valid_i & (instr_type == JAL);
    assign redirect_target_o = redirect_o ? pc_i + imm : '0;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            decode_q.valid <= 1'b0;
        end else begin
            decode_q.valid <= instr_valid_i;
        end
        decode_q.instr_type <= instr_type;  // payload, qualified by valid
        decode_q.pc         <= pc_i;
        decode_q.imm        <= imm;
        decode_q.rs1        <= rs1;
        decode_q.rs2        <= rs2;
        decode_q.rd         <= rd;
    end

    assign decode_o = decode_q;

endmodule

// File: source/regfile.sv
// integer register file, 32 x 64 bits
// two combinational read ports, link and external write ports
`timescale 1ns/1ns

module regfile (
    input  logic                clk_i,
    input  logic                reset_i,
    input  drac_pkg::reg_addr_t rs1_addr_i,
    input  drac_pkg::reg_addr_t rs2_addr_i,
    output drac_pkg::bus64_t    rs1_data_o,
    output drac_pkg::bus64_t    rs2_data_o,
    input  drac_pkg::reg_wr_t   link_wr_i,
    input  drac_pkg::reg_wr_t   ext_wr_i
);
    import drac_pkg::*;

    bus64_t regs_q [NUM_REGS];  // entry 0 never written

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            if (ext_wr_i.valid && (ext_wr_i.addr != '0)) begin
                regs_q[ext_wr_i.addr] <= ext_wr_i.data;
            end
            // later assignment wins, so link beats ext on the same rd
            // link requests never target x0, resolve filters them
            if (link_wr_i.valid) begin
                regs_q[link_wr_i.addr] <= link_wr_i.data;
            end
        end
    end

    // x0 reads as zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

// File: execute/branch_unit.sv
// branch unit, purely combinational
// compare conditions, taken, target, next pc and link value
`timescale 1ns/1ns

module branch_unit (
    input  drac_pkg::instr_type_t instr_type_i,
    input  drac_pkg::addrPC_t     pc_i,
    input  drac_pkg::bus64_t      data_rs1_i,
    input  drac_pkg::bus64_t      data_rs2_i,
    input  drac_pkg::bus64_t      imm_i,
    output logic                  taken_o,
    output drac_pkg::addrPC_t     target_o,
    output drac_pkg::addrPC_t     result_o,
    output drac_pkg::bus64_t      reg_data_o
);
    import drac_pkg::*;

    logic    eq;
    logic    lt_s;
    logic    lt_u;
    addrPC_t pc_plus4;

    // all three compares evaluated once, shared by the six branches
    assign eq       = (data_rs1_i == data_rs2_i);
    assign lt_s     = ($signed(data_rs1_i) < $signed(data_rs2_i));
    assign lt_u     = (data_rs1_i < data_rs2_i);
    assign pc_plus4 = pc_i + 64'd4;

    always_comb begin
        case (instr_type_i)
            JAL:  target_o = pc_i + imm_i;
            JALR: target_o = data_rs1_i + imm_i;   // alignment not checked
            BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
                target_o = pc_i + imm_i;
            end
            default: begin
                target_o = '0;                       // nop
            end
        endcase
    end

    always_comb begin
        case (instr_type_i)
            JAL:     taken_o = 1'b0;    // already redirected in decode
            JALR:    taken_o = 1'b1;    // unconditional, target needs rs1
            BEQ:     taken_o = eq;
            BNE:     taken_o = ~eq;
            BLT:     taken_o = lt_s;
            BGE:     taken_o = ~lt_s;
            BLTU:    taken_o = lt_u;
            BGEU:    taken_o = ~lt_u;
            default: taken_o = 1'b0;
        endcase
    end

    assign result_o   = taken_o ? target_o : pc_plus4;
    assign reg_data_o = pc_plus4;   // link value for jal, jalr

endmodule

// File: execute/branch_exec_stage.sv
// execute stage of the branch pipeline
// register file read with forwarding from resolve
// branch unit instance and execute pipeline register
`timescale 1ns/1ns

module branch_exec_stage (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  drac_pkg::decode_out_t decode_i,
    output drac_pkg::reg_addr_t   rs1_addr_o,
    output drac_pkg::reg_addr_t   rs2_addr_o,
    input  drac_pkg::bus64_t      rs1_data_i,
    input  drac_pkg::bus64_t      rs2_data_i,
    input  drac_pkg::reg_wr_t     fwd_i,
    output drac_pkg::exec_out_t   exec_o
);
    import drac_pkg::*;

    bus64_t    data_rs1;
    bus64_t    data_rs2;
    logic      taken;
    addrPC_t   target;
    addrPC_t   result;
    bus64_t    reg_data;
    exec_out_t exec_q;

    assign rs1_addr_o = decode_i.rs1;
    assign rs2_addr_o = decode_i.rs2;

    // link write in resolve has not reached the regfile yet
    // fwd_i never carries x0, resolve filters it
    assign data_rs1 = (fwd_i.valid && (fwd_i.addr == decode_i.rs1)) ? fwd_i.data : rs1_data_i;
    assign data_rs2 = (fwd_i.valid && (fwd_i.addr == decode_i.rs2)) ? fwd_i.data : rs2_data_i;

    branch_unit branch_unit_inst (
        .instr_type_i (decode_i.instr_type),
        .pc_i         (decode_i.pc),
        .data_rs1_i   (data_rs1),
        .data_rs2_i   (data_rs2),
        .imm_i        (decode_i.imm),
        .taken_o      (taken),
        .target_o     (target),
        .result_o     (result),
        .reg_data_o   (reg_data)
    );

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            exec_q.valid <= 1'b0;
        end else begin
            exec_q.valid <= decode_i.valid;
        end
        exec_q.instr_type <= decode_i.instr_type;
        exec_q.pc         <= decode_i.pc;
        exec_q.taken      <= taken;
        exec_q.target     <= target;
        exec_q.result     <= result;     // next pc
        exec_q.reg_data   <= reg_data;
        exec_q.rd         <= decode_i.rd;
    end

    assign exec_o = exec_q;

endmodule

// File: source/branch_resolve_stage.sv
// resolve stage of the branch pipeline
// resolution outputs gated by valid
// link write request for jal and jalr, also the forwarding source
`timescale 1ns/1ns

module branch_resolve_stage (
    input  drac_pkg::exec_out_t exec_i,
    output logic                resolve_valid_o,
    output logic                taken_o,
    output drac_pkg::addrPC_t   target_o,
    output drac_pkg::addrPC_t   next_pc_o,
    output drac_pkg::reg_wr_t   link_wr_o
);
    import drac_pkg::*;

    logic is_jump;
    logic link_en;

    assign is_jump = (exec_i.instr_type == JAL) || (exec_i.instr_type == JALR);

    // rd == x0 means a plain jump, nothing to link
    assign link_en = exec_i.valid & is_jump & (exec_i.rd != '0);

    assign resolve_valid_o = exec_i.valid;
    assign taken_o         = exec_i.valid & exec_i.taken;
    assign target_o        = exec_i.valid ? exec_i.target : '0;
    assign next_pc_o       = exec_i.valid ? exec_i.result : '0;

    // lands in the regfile on the next edge
    assign link_wr_o.valid = link_en;
    assign link_wr_o.addr  = exec_i.rd;
    assign link_wr_o.data  = exec_i.reg_data;   // pc+4

endmodule

// File: source/branch_pipe_top.sv
// top level of the branch resolution pipeline
// decode, execute and resolve stages around the register file
`timescale 1ns/1ns

module branch_pipe_top (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                instr_valid_i,
    input  drac_pkg::instr_u    instr_i,
    input  drac_pkg::addrPC_t   pc_i,
    input  drac_pkg::reg_wr_t   ext_wr_i,
    output logic                decode_redirect_o,
    output drac_pkg::addrPC_t   decode_target_o,
    output logic                resolve_valid_o,
    output logic                taken_o,
    output drac_pkg::addrPC_t   target_o,
    output drac_pkg::addrPC_t   next_pc_o
);
    import drac_pkg::*;

    decode_out_t decode;        // decode -> execute
    exec_out_t   exec;          // execute -> resolve
    reg_wr_t     link_wr;       // resolve -> regfile and forwarding
    reg_addr_t   rs1_addr;
    reg_addr_t   rs2_addr;
    bus64_t      rs1_data;
    bus64_t      rs2_data;

    branch_decode_stage decode_stage_inst (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .instr_valid_i     (instr_valid_i),
        .instr_i           (instr_i),
        .pc_i              (pc_i),
        .redirect_o        (decode_redirect_o),
        .redirect_target_o (decode_target_o),
        .decode_o          (decode)
    );

    regfile regfile_inst (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .link_wr_i  (link_wr),
        .ext_wr_i   (ext_wr_i)
    );

    branch_exec_stage exec_stage_inst (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .decode_i   (decode),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .fwd_i      (link_wr),
        .exec_o     (exec)
    );

    branch_resolve_stage resolve_stage_inst (
        .exec_i          (exec),
        .resolve_valid_o (resolve_valid_o),
        .taken_o         (taken_o),
        .target_o        (target_o),
        .next_pc_o       (next_pc_o),
        .link_wr_o       (link_wr)
    );

endmodule

// File: verif/tb_clock_gen.sv
// testbench clock and reset generator
// 10 ns clock, synchronous reset held for 3 cycles
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;  // 10 ns period
    end

    initial begin
        reset_o = 1'b1;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);   // release away from the sampling edge
        reset_o = 1'b0;
    end

endmodule

// File: verif/branch_pipe_checker.sv
// checker for the branch pipeline
// queue of expected resolutions, jal redirect expectation
// compares dut outputs on the rising edge, counts errors
`timescale 1ns/1ns

module branch_pipe_checker (
    input logic              clk_i,
    input logic              reset_i,
    input logic              decode_redirect_i,
    input drac_pkg::addrPC_t decode_target_i,
    input logic              resolve_valid_i,
    input logic              taken_i,
    input drac_pkg::addrPC_t target_i,
    input drac_pkg::addrPC_t next_pc_i
);
    import drac_pkg::*;

    typedef struct packed {
        logic    taken;
        addrPC_t target;
        addrPC_t next_pc;
    } expect_t;

    expect_t exp_q [$];             // oldest instruction at the front
    logic    exp_redirect = 1'b0;   // set by the stimulus for the next edge only
    addrPC_t exp_redirect_target = '0;
    int      mismatch_count = 0;
    int      other_count = 0;

    task automatic push_result(input logic taken, input addrPC_t target,
                               input addrPC_t next_pc);
        exp_q.push_back({taken, target, next_pc});
    endtask

    task automatic expect_redirect(input logic redirect, input addrPC_t target);
        exp_redirect        = redirect;
        exp_redirect_target = target;
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic check_value(input string name, input addrPC_t got, input addrPC_t want);
        if (got !== want) begin
            $display("FAILED at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
            mismatch_count++;
        end
    endtask

    // outputs read before this edge updates the pipeline registers
    always @(posedge clk_i) begin
        expect_t want;
        if (!reset_i) begin
            check_value("decode_redirect_o", 64'(decode_redirect_i), 64'(exp_redirect));
            if (exp_redirect) begin
                check_value("decode_target_o", decode_target_i, exp_redirect_target);
            end
            if (resolve_valid_i === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("resolve_valid_o at %0t ns with no instruction in flight", $time);
                    other_count++;
                end else begin
                    want = exp_q.pop_front();
                    check_value("taken_o", 64'(taken_i), 64'(want.taken));
                    check_value("target_o", target_i, want.target);
                    check_value("next_pc_o", next_pc_i, want.next_pc);
                end
            end else if (resolve_valid_i !== 1'b0) begin
                $display("resolve_valid_o is unknown at %0t ns", $time);
                other_count++;
            end
        end
        exp_redirect = 1'b0;    // idle cycles expect no redirect
    end

    task automatic final_check();
        if (exp_q.size() != 0) begin
            $display("%0d expected resolutions never arrived", exp_q.size());
            other_count += exp_q.size();
        end
    endtask

endmodule

// File: verif/branch_pipe_assertions.sv
// concurrent assertions on the branch pipeline top level
// quiet outputs in reset, redirect only with valid input
// two cycle latency in both directions, taken only with valid
`timescale 1ns/1ns

module branch_pipe_assertions (
    input logic clk_i,
    input logic reset_i,
    input logic instr_valid_i,
    input logic decode_redirect_i,
    input logic resolve_valid_i,
    input logic taken_i
);

    int fail_count = 0;     // read by the testbench at the end

    // second reset edge onwards, the registers are cleared by then
    reset_quiet: assert property (@(posedge clk_i)
        (reset_i && $past(reset_i)) |-> (!resolve_valid_i && !taken_i && !decode_redirect_i))
        else begin
            fail_count++;
            $error("output valid asserted during reset");
        end

    redirect_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
        decode_redirect_i |-> instr_valid_i)
        else begin
            fail_count++;
            $error("decode redirect without a valid instruction");
        end

    latency_two: assert property (@(posedge clk_i) disable iff (reset_i)
        instr_valid_i |-> ##2 resolve_valid_i)
        else begin
            fail_count++;
            $error("instruction not resolved two cycles after issue");
        end

    resolve_has_source: assert property (@(posedge clk_i) disable iff (reset_i)
        resolve_valid_i |-> $past(instr_valid_i, 2))
        else begin
            fail_count++;
            $error("resolution without an instruction two cycles earlier");
        end

    taken_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
        taken_i |-> resolve_valid_i)
        else begin
            fail_count++;
            $error("taken without resolve valid");
        end

endmodule

bind branch_pipe_top branch_pipe_assertions assert_inst (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .instr_valid_i     (instr_valid_i),
    .decode_redirect_i (decode_redirect_o),
    .resolve_valid_i   (resolve_valid_o),
    .taken_i           (taken_o)
);

// File: verif/branch_pipe_tb.sv
// testbench top for the branch resolution pipeline
// clock, dut, checker, shadow register file and reference model
// directed and random stimulus, closing verdict
`timescale 1ns/1ns

module branch_pipe_tb;
    import drac_pkg::*;

    typedef struct packed {
        logic    taken;
        addrPC_t target;
        addrPC_t next_pc;
    } ref_t;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    instr_u      instr;
    addrPC_t     pc;
    reg_wr_t     ext_wr;
    logic        decode_redirect;
    addrPC_t     decode_target;
    logic        resolve_valid;
    logic        taken;
    addrPC_t     target;
    addrPC_t     next_pc;
    bus64_t      shadow [NUM_REGS];     // program order view of the regfile
    instr_type_t br_types [6] = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
    int          wait_n;
    int          timed_out;
    int          total_errors;

    tb_clock_gen clock_gen_inst (
        .clk_o   (clk),
        .reset_o (reset)
    );

    branch_pipe_top DUT (
        .clk_i             (clk),
        .reset_i           (reset),
        .instr_valid_i     (instr_valid),
        .instr_i           (instr),
        .pc_i              (pc),
        .ext_wr_i          (ext_wr),
        .decode_redirect_o (decode_redirect),
        .decode_target_o   (decode_target),
        .resolve_valid_o   (resolve_valid),
        .taken_o           (taken),
        .target_o          (target),
        .next_pc_o         (next_pc)
    );

    branch_pipe_checker checker_inst (
        .clk_i             (clk),
        .reset_i           (reset),
        .decode_redirect_i (decode_redirect),
        .decode_target_i   (decode_target),
        .resolve_valid_i   (resolve_valid),
        .taken_i           (taken),
        .target_i          (target),
        .next_pc_i         (next_pc)
    );

    // expected resolution from the isa rules
    function automatic ref_t resolve_ref(input instr_type_t t, input addrPC_t pc_v,
                                         input bus64_t imm, input bus64_t a, input bus64_t b);
        ref_t r;
        r.taken  = 1'b0;
        r.target = pc_v + imm;  // pc relative unless jalr
        case (t)
            JAL:  r.taken = 1'b0;   // redirected at decode
            JALR: begin
                r.taken  = 1'b1;
                r.target = a + imm;
            end
            BEQ:  r.taken = (a == b);
            BNE:  r.taken = (a != b);
            BLT:  r.taken = ($signed(a) < $signed(b));
            BGE:  r.taken = ($signed(a) >= $signed(b));
            BLTU: r.taken = (a < b);
            BGEU: r.taken = (a >= b);
            default: r.target = '0;
        endcase
        r.next_pc = r.taken ? r.target : pc_v + 64'd4;
        return r;
    endfunction

    // rv64 b, j and i formats
    function automatic logic [31:0] encode(input instr_type_t t, input reg_addr_t rd,
                                           input reg_addr_t rs1, input reg_addr_t rs2,
                                           input bus64_t imm);
        logic [2:0] f3;
        case (t)
            BNE:     f3 = 3'b001;
            BLT:     f3 = 3'b100;
            BGE:     f3 = 3'b101;
            BLTU:    f3 = 3'b110;
            BGEU:    f3 = 3'b111;
            default: f3 = 3'b000;
        endcase
        case (t)
            JAL:     return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
            JALR:    return {imm[11:0], rs1, 3'b000, rd, 7'b1100111};
            default: return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
        endcase
    endfunction

    task automatic issue_word(input logic [31:0] word, input instr_type_t t,
                              input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2,
                              input bus64_t imm, input addrPC_t pc_v);
        ref_t r;
        @(negedge clk);
        r            = resolve_ref(t, pc_v, imm, shadow[rs1], shadow[rs2]);
        instr_valid  = 1'b1;
        instr.raw    = word;
        pc           = pc_v;
        ext_wr.valid = 1'b0;
        checker_inst.expect_redirect(t == JAL, pc_v + imm);
        checker_inst.push_result(r.taken, r.target, r.next_pc);
        if ((t == JAL || t == JALR) && rd != '0) begin
            shadow[rd] = pc_v + 64'd4;  // link value
        end
    endtask

    task automatic issue_instr(input instr_type_t t, input reg_addr_t rd, input reg_addr_t rs1,
                               input reg_addr_t rs2, input bus64_t imm, input addrPC_t pc_v);
        issue_word(encode(t, rd, rs1, rs2, imm), t, rd, rs1, rs2, imm, pc_v);
    endtask

    task automatic idle();
        @(negedge clk);
        instr_valid  = 1'b0;
        ext_wr.valid = 1'b0;
    endtask

    task automatic write_reg(input reg_addr_t addr, input bus64_t data);
        @(negedge clk);
        instr_valid = 1'b0;
        ext_wr      = '{valid: 1'b1, addr: addr, data: data};
        if (addr != '0) begin
            shadow[addr] = data;    // x0 write dropped
        end
    endtask

    task automatic preload_regs();
        for (int r = 1; r < NUM_REGS; r++) begin
            write_reg(reg_addr_t'(r), {$urandom, $urandom});
        end
        write_reg(5'd2, shadow[1]);                 // equal pair x1 x2
        write_reg(5'd3, 64'h8000_0000_0000_0000);   // most negative
        write_reg(5'd4, 64'h7fff_ffff_ffff_ffff);   // most positive
        write_reg(5'd5, 64'h0);
        write_reg(5'd6, 64'hffff_ffff_ffff_ffff);   // -1, unsigned max
        write_reg(5'd12, 64'h1004);                 // pc+4 of the link tests
        write_reg(5'd0, 64'hdead_beef);
        idle();     // external writes are not forwarded
    endtask

    task automatic run_directed();
        reg_addr_t pa [5];
        reg_addr_t pb [5];
        pa = '{5'd1, 5'd3, 5'd4, 5'd5, 5'd6};
        pb = '{5'd2, 5'd4, 5'd3, 5'd6, 5'd5};
        // every branch type on equal and boundary pairs, back to back
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 5; p++) begin
                issue_instr(br_types[k], 5'd0, pa[p], pb[p],
                            p[0] ? 64'hffff_ffff_ffff_fff0 : 64'h100,
                            64'h2000 + 64'(k * 64 + p * 4));
            end
        end
        issue_instr(JAL, 5'd7, 5'd0, 5'd0, 64'h800, 64'h3000);
        issue_instr(JAL, 5'd8, 5'd0, 5'd0, 64'hffff_ffff_ffff_f000, 64'h3100);   // backward
        issue_instr(JAL, 5'd9, 5'd0, 5'd0, 64'h40, 64'h1000);      // x9 = 0x1004
        issue_instr(BEQ, 5'd0, 5'd9, 5'd12, 64'h20, 64'h1040);     // rs1 forwarded
        issue_instr(JALR, 5'd13, 5'd5, 5'd0, 64'h44, 64'h1000);    // x13 = 0x1004
        issue_instr(BNE, 5'd0, 5'd12, 5'd13, 64'h20, 64'h1050);    // rs2 forwarded
        issue_instr(JAL, 5'd14, 5'd0, 5'd0, 64'h8, 64'h1000);
        issue_word(32'h0000_0013, NOP, 5'd0, 5'd0, 5'd0, 64'h0, 64'h1100);  // addi nop
        issue_instr(BEQ, 5'd0, 5'd14, 5'd12, 64'h10, 64'h1104);    // distance two
        issue_instr(JAL, 5'd0, 5'd0, 5'd0, 64'h10, 64'h1200);      // link to x0
        issue_instr(BEQ, 5'd0, 5'd0, 5'd5, 64'h10, 64'h1204);      // x0 still zero
        issue_instr(JALR, 5'd0, 5'd12, 5'd0, 64'h0, 64'h1300);
        issue_instr(BGEU, 5'd0, 5'd5, 5'd0, 64'h18, 64'h1304);
        issue_word({7'd0, 5'd2, 5'd1, 3'b010, 5'd0, 7'b1100011}, NOP,
                   5'd0, 5'd1, 5'd2, 64'h0, 64'h1308);             // funct3 010
        idle();
        issue_instr(BEQ, 5'd0, 5'd13, 5'd12, 64'h20, 64'h1400);    // jalr link from regfile
    endtask

    task automatic run_random(input int count);
        int          kind;
        addrPC_t     pc_r;
        reg_addr_t   rd_r;
        reg_addr_t   rs1_r;
        reg_addr_t   rs2_r;
        logic [12:0] b13;
        logic [20:0] j21;
        logic [11:0] i12;
        logic [31:0] word;
        for (int i = 0; i < count; i++) begin
            kind  = int'($urandom_range(0, 9));
            pc_r  = {32'h0, $urandom & 32'hffff_fffc};
            rd_r  = 5'($urandom);
            rs1_r = 5'($urandom);
            rs2_r = 5'($urandom);
            b13   = 13'($urandom & 32'h1ffe);   // even offsets
            j21   = 21'($urandom & 32'h1f_fffe);
            i12   = 12'($urandom);
            if (kind < 6) begin
                issue_instr(br_types[kind], 5'd0, rs1_r, rs2_r, {{51{b13[12]}}, b13}, pc_r);
            end else if (kind == 6) begin
                issue_instr(JAL, rd_r, 5'd0, 5'd0, {{43{j21[20]}}, j21}, pc_r);
            end else if (kind == 7) begin
                issue_instr(JALR, rd_r, rs1_r, 5'd0, {{52{i12[11]}}, i12}, pc_r);
            end else begin
                word      = $urandom;
                word[6:0] = (kind == 8) ? 7'b0010011 : 7'b0110011;    // op-imm, op
                issue_word(word, NOP, 5'd0, 5'd0, 5'd0, 64'h0, pc_r);
            end
        end
    endtask

    initial begin
        void'($urandom(32'h5072_fdb1));
        instr_valid = 1'b0;
        instr.raw   = '0;
        pc          = '0;
        ext_wr      = '0;
        timed_out   = 0;
        for (int r = 0; r < NUM_REGS; r++) begin
            shadow[r] = '0;
        end

        @(negedge clk);
        wait_n = 0;
        while (reset !== 1'b0 && wait_n < 20) begin
            @(negedge clk);
            wait_n++;
        end
        if (reset !== 1'b0) begin
            $display("reset was never released");
            timed_out = 1;
        end else begin
            preload_regs();
            run_directed();
            run_random(200);
        end
        idle();

        wait_n = 0;
        while (checker_inst.pending() != 0 && wait_n < 20) begin
            @(negedge clk);
            wait_n++;
        end
        if (checker_inst.pending() != 0) begin
            $display("timeout waiting for %0d resolutions", checker_inst.pending());
            timed_out = 1;
        end
        repeat (3) @(negedge clk);  // stray resolutions show up here
        checker_inst.final_check();

        total_errors = checker_inst.mismatch_count + checker_inst.other_count
                     + DUT.assert_inst.fail_count + timed_out;
        $display("errors: %0d mismatches, %0d other, %0d assertion failures, %0d timeouts",
                 checker_inst.mismatch_count, checker_inst.other_count,
                 DUT.assert_inst.fail_count, timed_out);
        if (total_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: branch_pipe_top.f
common/drac_pkg.sv
source/branch_decode_stage.sv
source/regfile.sv
execute/branch_unit.sv
execute/branch_exec_stage.sv
source/branch_resolve_stage.sv
source/branch_pipe_top.sv
verif/tb_clock_gen.sv
verif/branch_pipe_checker.sv
verif/branch_pipe_assertions.sv
verif/branch_pipe_tb.sv
